// File: rtl/tile_pkg.sv
// =========================================================================
// Shared row geometry, data types and FSM encoding of the tile-layer engine
// Fetchers and the top level import it, the row buffers use its types only
// =========================================================================
`default_nettype none

package tile_pkg;

    // =========================================================================
    // Row geometry
    // =========================================================================
    localparam int unsigned chunk_count    = 11;  // Tile-RAM reads per scan row
    localparam int unsigned slot_count     = 44;  // Four entries per chunk
    localparam int unsigned map_chunks     = 16;  // 64-tile map row, 4 tiles a chunk
    localparam int unsigned visible_pixels = 320; // 40 tiles of 8 pixels on screen

    // One tile-map entry as held in tile RAM
    typedef struct packed {
        logic [9:0] pattern_base; // Pattern-RAM tile, word index goes below it
        logic [3:0] palette;      // Sent to the mixer with each colour
        logic       y_mirror;     // Flip rows top to bottom
        logic       x_mirror;     // Flip pixels left to right
    } tile_entry_t;

    // Four entries, entry 0 in bits 15:0
    typedef logic [63:0] tile_chunk_t;

    // Two pattern rows, even row in the low half
    typedef logic [63:0] pattern_word_t;

    // Eight 4-bit pixels, pixel k at nibble k
    typedef logic [31:0] pixel_row_t;

    // 9-bit scroll or pixel-row position, wraps at 512
    typedef logic [8:0] scroll_t;

    // Mixer pixel, palette in the high nibble
    typedef logic [7:0] pixel_t;

    // =========================================================================
    // Control FSM
    // =========================================================================
    typedef enum logic [1:0] {
        st_idle,          // Serving pixel reads
        st_tile_fetch,    // Copying tile-map chunks
        st_pattern_fetch  // Fetching one pattern row per entry
    } engine_state_e;

endpackage : tile_pkg

`default_nettype wire

// File: rtl/tile_row_fetcher.sv
// =========================================================================
// Copies the eleven tile-map chunks of one scan row from tile RAM into the
// tile row buffer. Starts on a one-cycle start strobe, pulses done after
// the last buffer write. The chunk index wraps inside the 64-tile map row
// =========================================================================
`timescale 1ns/100ps
`default_nettype none

module tile_row_fetcher (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire  [3:0]                  first_chunk,   // Chunk holding the leftmost tile
    input  wire  [5:0]                  tile_row,      // Map row of the scan line
    input  wire  tile_pkg::tile_chunk_t tilram_rddata,
    output logic [9:0]                  tilram_addr,   // Layer bit added by the top level
    output logic                        wr_en,
    output logic [3:0]                  wr_addr,
    output tile_pkg::tile_chunk_t       wr_data,
    output logic                        done
);
    import tile_pkg::*;

    logic       fetching;   // Address phase, one chunk per cycle
    logic [3:0] chunk_cnt;  // Chunks issued so far
    logic [3:0] map_chunk;  // Chunk within the map row

    // Four-bit sum wraps back to the start of the map row past chunk 15
    assign map_chunk = first_chunk + chunk_cnt;

    assign tilram_addr = {tile_row, map_chunk};
    assign wr_data     = tilram_rddata; // Data of the previous cycle's address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetching  <= 1'b0;
            chunk_cnt <= '0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
            done      <= 1'b0;
        end else begin
            wr_en   <= fetching;   // Write trails its address by one cycle
            wr_addr <= chunk_cnt;  // Buffer words 0 to 10 in order
            done    <= wr_en && (wr_addr == 4'(chunk_count - 1));
            if (start) begin
                fetching  <= 1'b1;
                chunk_cnt <= '0;
            end else if (fetching) begin
                if (chunk_cnt == 4'(chunk_count - 1)) begin
                    fetching <= 1'b0;  // Last address out
                end else begin
                    chunk_cnt <= chunk_cnt + 4'd1;
                end
            end
        end
    end

    // Controller must let the previous copy drain before the next row
    a_start_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !(fetching || wr_en)
    ) else $error("tile_row_fetcher: start while a copy is in flight");

endmodule : tile_row_fetcher

`default_nettype wire

// File: rtl/tile_row_buffer.sv
// =========================================================================
// Tile row buffer. Chunk-wide write port for the tile fetcher, entry-wide
// registered read port shared by the pattern fetcher and the pixel path
// =========================================================================
`timescale 1ns/100ps
`default_nettype none

module tile_row_buffer #(
    parameter int unsigned slots = tile_pkg::slot_count  // Entries filled per row
) (
    input  wire                         clk,
    input  wire                         wr_en,
    input  wire  [3:0]                  wr_addr,
    input  wire  tile_pkg::tile_chunk_t wr_data,
    input  wire  [5:0]                  rd_slot,
    output tile_pkg::tile_entry_t       rd_entry
);

    logic [63:0] mem [16];  // One word per chunk

    // Chunk write from the tile fetcher
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Slot s lives in word s/4, sub-word s mod 4
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_slot[5:2]][16 * rd_slot[1:0] +: 16];
    end

    // Slots past the fetched ones were never written this row
    a_slot_range : assert property (
        @(posedge clk) rd_slot < 6'(slots)
    ) else $error("tile_row_buffer: read of slot %0d", rd_slot);

endmodule : tile_row_buffer

`default_nettype wire

// File: rtl/pattern_row_fetcher.sv
// =========================================================================
// Walks the 44 fetched tile entries, reads one pattern word per entry and
// writes the selected, mirrored pixel row into the pixel row buffer.
// Three-stage pipeline: entry read, pattern address, pixel-buffer write
// =========================================================================
`timescale 1ns/100ps
`default_nettype none

module pattern_row_fetcher (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start,
    input  wire  [2:0]                    row_in_tile,   // Pixel row within the tile
    input  wire  tile_pkg::tile_entry_t   entry,         // Tile buffer read data
    input  wire  tile_pkg::pattern_word_t patram_rddata,
    output logic [5:0]                    slot,          // Tile buffer read slot
    output logic                          busy,
    output logic [11:0]                   patram_addr,
    output logic                          wr_en,
    output logic [5:0]                    wr_addr,
    output tile_pkg::pixel_row_t          wr_data,
    output logic                          done
);
    import tile_pkg::*;

    logic       issuing;     // Slot counter running
    logic       valid_1;     // Entry on the buffer read port
    logic       valid_2;     // Pattern word on patram_rddata
    logic [5:0] slot_1;
    logic [5:0] slot_2;
    logic       half_2;      // Odd row, take the high half
    logic       x_mirror_2;
    logic [2:0] eff_row;     // Row after Y mirror
    logic       last_write;
    pixel_row_t half_row;
    pixel_row_t flipped_row;

    // =========================================================================
    // Stage 2 forms the pattern address from the returned entry
    // =========================================================================
    // 7 - r on three bits
    assign eff_row     = entry.y_mirror ? ~row_in_tile : row_in_tile;
    assign patram_addr = {entry.pattern_base, eff_row[2:1]}; // Two rows per word

    // =========================================================================
    // Stage 3 selects the row, mirrors it and writes it
    // =========================================================================
    assign half_row = half_2 ? patram_rddata[63:32] : patram_rddata[31:0];

    // Nibble order reversed for a left-right flip
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            flipped_row[4*k +: 4] = half_row[4*(7-k) +: 4];
        end
    end

    assign wr_data    = x_mirror_2 ? flipped_row : half_row;
    assign wr_en      = valid_2;
    assign wr_addr    = slot_2;
    assign last_write = valid_2 && (slot_2 == 6'(slot_count - 1));

    // Pipeline control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issuing <= 1'b0;
            slot    <= '0;
            valid_1 <= 1'b0;
            valid_2 <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else begin
            valid_1 <= issuing;
            valid_2 <= valid_1;
            done    <= last_write;
            if (start) begin
                issuing <= 1'b1;
                slot    <= '0;
                busy    <= 1'b1;
            end else begin
                if (issuing) begin
                    if (slot == 6'(slot_count - 1)) begin
                        issuing <= 1'b0;   // Last slot issued
                    end else begin
                        slot <= slot + 6'd1;
                    end
                end
                if (last_write) begin
                    busy <= 1'b0;          // Pipeline drained
                end
            end
        end
    end

    // Per-slot data carried alongside the valids
    always_ff @(posedge clk) begin
        slot_1     <= slot;
        slot_2     <= slot_1;
        half_2     <= eff_row[0];
        x_mirror_2 <= entry.x_mirror;
    end

    // busy must cover every write the pipeline still holds
    a_write_in_busy : assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |-> busy
    ) else $error("pattern_row_fetcher: write after busy dropped");

endmodule : pattern_row_fetcher

`default_nettype wire

// File: rtl/pixel_row_buffer.sv
// =========================================================================
// Pixel row buffer. One 8-pixel row per tile slot, written by the pattern
// fetcher, read one 4-bit colour at a time with one cycle of latency
// =========================================================================
`timescale 1ns/100ps
`default_nettype none

module pixel_row_buffer (
    input  wire                        clk,
    input  wire                        wr_en,
    input  wire  [5:0]                 wr_addr,
    input  wire  tile_pkg::pixel_row_t wr_data,
    input  wire  [5:0]                 rd_slot,
    input  wire  [2:0]                 rd_pixel,   // Pixel within the slot's row
    output logic [3:0]                 rd_color
);

    logic [31:0] mem [64];  // Slots 0 to 43 hold this row

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Pixel k sits at nibble k
    always_ff @(posedge clk) begin
        rd_color <= mem[rd_slot][4 * rd_pixel +: 4];
    end

endmodule : pixel_row_buffer

`default_nettype wire

// File: rtl/tile_engine.sv
// =========================================================================
// Scrolling tile layer for the pixel pipeline. On prep it copies a row of
// tile-map entries, then one pattern row per entry, and pulses done. In
// idle the mixer reads {palette, colour} with one cycle of latency
// =========================================================================
`timescale 1ns/100ps
`default_nettype none

module tile_engine #(
    parameter bit fg_layer = 1'b0  // Selects the foreground half of tile RAM
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               prep,
    input  wire               enable,         // Low blanks the layer
    input  wire  [31:0]       scroll,         // Y in 24:16, X in 8:0
    input  wire  [7:0]        next_row,       // Scan line being prepared
    input  wire  [63:0]       tilram_rddata,
    input  wire  [63:0]       patram_rddata,
    input  wire  [8:0]        pixel_addr,
    output logic [10:0]       tilram_addr,
    output logic [11:0]       patram_addr,
    output tile_pkg::pixel_t  pixel_data,
    output logic              done
);
    import tile_pkg::*;

    engine_state_e state;
    scroll_t       scroll_x_q;    // X scroll held for the whole row
    scroll_t       pixel_row_q;   // scroll_y + next_row, mod 512
    logic          enable_q;      // Aligned with the read data

    // Tile fetch side
    logic          tile_start;
    logic          tile_done;
    logic [9:0]    tile_fetch_addr;
    logic          tile_wr_en;
    logic [3:0]    tile_wr_addr;
    tile_chunk_t   tile_wr_data;

    // Pattern fetch side
    logic          pattern_start;
    logic          pattern_done;
    logic          pattern_busy;
    logic [5:0]    pattern_slot;
    logic          pix_wr_en;
    logic [5:0]    pix_wr_addr;
    pixel_row_t    pix_wr_data;

    // Read side
    logic [8:0]    pixel_sum;     // Pixel position within the fetched row
    logic [5:0]    tile_rd_slot;
    tile_entry_t   tile_entry;
    logic [3:0]    pixel_color;

    // =========================================================================
    // Control FSM and row latches
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            tile_start    <= 1'b0;
            pattern_start <= 1'b0;
            done          <= 1'b0;
            enable_q      <= 1'b0;
            scroll_x_q    <= '0;
            pixel_row_q   <= '0;
        end else begin
            tile_start    <= 1'b0;  // Strobes last one cycle
            pattern_start <= 1'b0;
            done          <= 1'b0;
            enable_q      <= enable;
            case (state)
                st_idle: begin
                    if (prep) begin
                        state       <= st_tile_fetch;
                        tile_start  <= 1'b1;
                        scroll_x_q  <= scroll[8:0];
                        pixel_row_q <= scroll[24:16] + {1'b0, next_row};  // Wraps at 512
                    end
                end
                st_tile_fetch: begin
                    if (tile_done) begin
                        state         <= st_pattern_fetch;
                        pattern_start <= 1'b1;
                    end
                end
                st_pattern_fetch: begin
                    if (pattern_done) begin
                        state <= st_idle;
                        done  <= 1'b1;  // Same edge as the return to idle
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // =========================================================================
    // Fetch pipeline
    // =========================================================================
    assign tilram_addr = {fg_layer, tile_fetch_addr};

    tile_row_fetcher u_tile_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (tile_start),
        .first_chunk   (scroll_x_q[8:5]),  // Four tiles of 8 pixels per chunk
        .tile_row      (pixel_row_q[8:3]),
        .tilram_rddata (tilram_rddata),
        .tilram_addr   (tile_fetch_addr),
        .wr_en         (tile_wr_en),
        .wr_addr       (tile_wr_addr),
        .wr_data       (tile_wr_data),
        .done          (tile_done)
    );

    // Pattern fetcher owns the read port while busy, the mixer otherwise
    assign pixel_sum    = pixel_addr + {4'b0, scroll_x_q[4:0]};
    assign tile_rd_slot = pattern_busy ? pattern_slot : pixel_sum[8:3];

    tile_row_buffer u_tile_buf (
        .clk      (clk),
        .wr_en    (tile_wr_en),
        .wr_addr  (tile_wr_addr),
        .wr_data  (tile_wr_data),
        .rd_slot  (tile_rd_slot),
        .rd_entry (tile_entry)
    );

    pattern_row_fetcher u_pattern_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (pattern_start),
        .row_in_tile   (pixel_row_q[2:0]),
        .entry         (tile_entry),
        .patram_rddata (patram_rddata),
        .slot          (pattern_slot),
        .busy          (pattern_busy),
        .patram_addr   (patram_addr),
        .wr_en         (pix_wr_en),
        .wr_addr       (pix_wr_addr),
        .wr_data       (pix_wr_data),
        .done          (pattern_done)
    );

    pixel_row_buffer u_pixel_buf (
        .clk      (clk),
        .wr_en    (pix_wr_en),
        .wr_addr  (pix_wr_addr),
        .wr_data  (pix_wr_data),
        .rd_slot  (pixel_sum[8:3]),
        .rd_pixel (pixel_sum[2:0]),
        .rd_color (pixel_color)
    );

    // Palette and colour both come back one cycle after the address
    assign pixel_data = enable_q ? {tile_entry.palette, pixel_color} : '0;

    // done only as the pattern phase hands back to idle
    a_done_in_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> (state == st_idle) && ($past(state) == st_pattern_fetch)
    ) else $error("tile_engine: done outside the return to idle");

    // Mixer reads stay on the visible row
    a_pixel_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == st_idle) |-> (pixel_addr < 9'(visible_pixels))
    ) else $error("tile_engine: pixel_addr %0d off the row", pixel_addr);

endmodule : tile_engine

`default_nettype wire

// File: verif/tile_engine_tests.svh
// =========================================================================
// Memory fill, reference model, compare tasks and directed tests for the
// tile engine testbench. Included inside the testbench module body
// =========================================================================
`ifndef TILE_ENGINE_TESTS_SVH
`define TILE_ENGINE_TESTS_SVH

// Random foreground map and patterns, background map derived from the address
task automatic fill_memories();
    logic [10:0] idx;
    for (int i = 0; i < 2048; i++) begin
        idx         = 11'(i);
        tilram[idx] = (idx[10] == fg_bit) ? {$urandom, $urandom} : {4{6'h2a, idx[9:0]}};
    end
    for (int i = 0; i < 4096; i++) begin
        patram[12'(i)] = {$urandom, $urandom};
    end
endtask

// Foreground half only, same mirror bits in all four entries of a chunk
task automatic force_mirrors(input logic [1:0] m);
    for (int i = 1024; i < 2048; i++) begin
        tilram[11'(i)] = (tilram[11'(i)] & ~64'h0003_0003_0003_0003) | {4{14'h0, m}};
    end
endtask

// =========================================================================
// Reference model
// =========================================================================
// Screen pixel addr shows map pixel scroll_x + addr, wrapping at 512
function automatic pixel_t model_pixel(input logic [8:0] addr);
    scroll_t       map_x;
    tile_entry_t   ent;
    logic [2:0]    r;
    logic [2:0]    px;
    pattern_word_t word;
    pixel_row_t    row;
    map_x = cur_scroll_x + addr;
    ent   = tilram[{fg_bit, cur_pixel_row[8:3], map_x[8:5]}][16 * map_x[4:3] +: 16];
    r     = ent.y_mirror ? 3'd7 - cur_pixel_row[2:0] : cur_pixel_row[2:0];
    word  = patram[{ent.pattern_base, r[2:1]}];       // Two rows per word
    row   = r[0] ? word[63:32] : word[31:0];          // Odd row in the high half
    px    = ent.x_mirror ? 3'd7 - map_x[2:0] : map_x[2:0];
    return {ent.palette, row[4 * px +: 4]};
endfunction

task automatic check_pixel(input logic [8:0] addr, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
        test_errors++;
        $display("MISMATCH pixel_data at pixel_addr 0x%03h: got 0x%02h expected 0x%02h",
                 addr, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        test_errors++;
        $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

task automatic report_failure(input string what);
    test_errors++;
    $display("ERROR %s", what);
endtask

task automatic end_test(input string name);
    tests++;
    errors += test_errors;
    $display("test %-16s %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
    test_errors = 0;
endtask

// Whole visible row, one read per cycle
task automatic sweep_row(input logic shown);
    for (int a = 0; a < int'(visible_pixels); a++) begin
        pixel_addr = 9'(a);
        @(posedge clk);
        #2;
        check_pixel(9'(a), pixel_data, shown ? model_pixel(9'(a)) : 8'h00);
    end
endtask

// One prep, optional second prep at cycle repeat_at, wait for done
task automatic run_prep(input scroll_t sx, input scroll_t sy, input logic [7:0] row,
                        input int repeat_at);
    int cycles;
    scroll        = {7'd0, sy, 7'd0, sx};
    next_row      = row;
    prep          = 1'b1;
    cur_scroll_x  = sx;
    cur_pixel_row = sy + scroll_t'(row);  // Effective pixel row, mod 512
    cycles        = 0;
    do begin
        @(posedge clk);
        #2;
        cycles++;
        prep   = (cycles == repeat_at);   // Lands while busy, must be ignored
        scroll = $urandom;                // Latched already, free to move
    end while (!done && cycles < prep_timeout);
    if (!done) begin
        abort_run("no done within 200 cycles of prep");
    end else begin
        if (cycles != prep_latency) begin
            report_failure($sformatf("done came %0d cycles after prep, not %0d",
                                     cycles, prep_latency));
        end
        @(posedge clk);
        #2;
        check_bit("done", done, 1'b0);    // One-cycle pulse
    end
endtask

// =========================================================================
// Directed tests
// =========================================================================
task automatic reset_state();
    for (int c = 0; c < 12; c++) begin
        @(posedge clk);
        #2;
        rst_n = (c >= 7);                 // Released after the eighth edge
        check_bit("done", done, 1'b0);
        check_pixel(pixel_addr, pixel_data, 8'h00);
    end
    end_test("reset_state");
endtask

task automatic unscrolled_row();
    enable = 1'b1;
    run_prep(9'd0, 9'd0, 8'($urandom), 0);
    sweep_row(1'b1);
    end_test("no_scroll");
endtask

task automatic x_scroll_wrap();
    run_prep(9'd319, 9'($urandom), 8'($urandom), 0);  // Chunks 9 to 19, wraps
    sweep_row(1'b1);
    run_prep(9'd500, 9'($urandom), 8'($urandom), 0);  // Starts on chunk 15
    sweep_row(1'b1);
    run_prep(9'd7, 9'($urandom), 8'($urandom), 0);    // Offset inside the first tile
    sweep_row(1'b1);
    end_test("x_scroll");
endtask

task automatic y_scroll_mirrors();
    for (int m = 0; m < 4; m++) begin
        force_mirrors(2'(m));
        run_prep(9'($urandom), 9'($urandom), 8'($urandom), 0);
        sweep_row(1'b1);
    end
    end_test("scroll_mirrors");
endtask

task automatic enable_blanking();
    enable = 1'b0;
    sweep_row(1'b0);                      // Blanked layer reads zero
    enable = 1'b1;
    sweep_row(1'b1);
    end_test("enable");
endtask

task automatic prep_timing_reject();
    run_prep(9'($urandom), 9'($urandom), 8'($urandom), 20);
    for (int c = 0; c < 80; c++) begin    // A taken second prep would show here
        @(posedge clk);
        #2;
        check_bit("done", done, 1'b0);
    end
    sweep_row(1'b1);                      // Still the first prep's row
    end_test("prep_timing");
endtask

`endif

// File: verif/tb_tile_engine.sv
// =========================================================================
// Testbench for the tile engine. Clock, reset, tile and pattern RAM models
// and the directed test sequence, the tests live in tile_engine_tests.svh
// =========================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_tile_engine;
    import tile_pkg::*;

    localparam bit fg_bit       = 1'b1;  // Layer the DUT is built for
    localparam int prep_latency = 63;    // prep edge to done
    localparam int prep_timeout = 200;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          prep;
    logic          enable;
    logic [31:0]   scroll;                // Y in 24:16, X in 8:0
    logic [7:0]    next_row;
    logic [8:0]    pixel_addr;
    logic [63:0]   tilram_rddata = '0;
    logic [63:0]   patram_rddata = '0;
    logic [10:0]   tilram_addr;
    logic [11:0]   patram_addr;
    pixel_t        pixel_data;
    logic          done;

    logic [63:0]   tilram [2048];         // Bit 10 of the address picks the layer
    logic [63:0]   patram [4096];

    int            tests       = 0;
    int            errors      = 0;
    int            test_errors = 0;       // Cleared as each test reports
    scroll_t       cur_scroll_x  = '0;    // What the engine latched at prep
    scroll_t       cur_pixel_row = '0;

    tile_engine #(.fg_layer(fg_bit)) uut (.*);

    initial begin
        forever #10 clk = ~clk;           // 20 ns period
    end

    // Both RAMs answer one cycle after the address
    always @(posedge clk) begin
        tilram_rddata <= tilram[tilram_addr];
        patram_rddata <= patram[patram_addr];
    end

    `include "tile_engine_tests.svh"

    // Timeout exit
    task automatic abort_run(input string what);
        $display("TIMEOUT %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    // =========================================================================
    // Test sequence
    // =========================================================================
    initial begin
        rst_n      = 1'b0;
        prep       = 1'b0;
        enable     = 1'b0;
        scroll     = '0;
        next_row   = '0;
        pixel_addr = '0;
        void'($urandom(32'ha5dc86bf));    // Single seed for the run
        fill_memories();
        reset_state();
        unscrolled_row();
        x_scroll_wrap();
        y_scroll_mirrors();
        enable_blanking();
        prep_timing_reject();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_tile_engine

`default_nettype wire

// File: tile_engine.f
+incdir+verif
rtl/tile_pkg.sv
rtl/tile_row_fetcher.sv
rtl/tile_row_buffer.sv
rtl/pattern_row_fetcher.sv
rtl/pixel_row_buffer.sv
rtl/tile_engine.sv
verif/tb_tile_engine.sv

// File: run_sim.sh
#!/bin/sh
# Build the tile engine testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tile_engine.f --top-module tb_tile_engine --Mdir build

./build/Vtb_tile_engine > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q "Simulation failed" build/sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" build/sim.log
